/* design/conv_row_pkg.sv */
package conv_row_pkg;

  //////////////////////////////////////////////////
  // widths that carry a meaning
  //////////////////////////////////////////////////

  // pixel or register index, also image width and tile column
  typedef logic [15:0] pix_idx_t;
  // kernel size, stride, padding, log2 of a width
  typedef logic [3:0] knl_t;
  // west/east pad and slab counts
  typedef logic [3:0] pad_t;

  // host port, classic wishbone
  typedef logic [31:0] wb_dat_t;
  typedef logic [2:0] wb_adr_t;

  //////////////////////////////////////////////////
  // register map (word addresses)
  //////////////////////////////////////////////////

  // k in 3:0, s in 7:4, p in 11:8
  localparam wb_adr_t reg_kernel = 3'd0;
  // ix in 15:0, log2 of ix in 19:16
  localparam wb_adr_t reg_width = 3'd1;
  // first output column of the tile, 1 based
  localparam wb_adr_t reg_tile = 3'd2;
  // output tile width
  localparam wb_adr_t reg_pox = 3'd3;
  // write bit 0 to start a run, read bit 0 for busy
  localparam wb_adr_t reg_ctrl = 3'd4;
  // descriptors issued since the last start
  localparam wb_adr_t reg_count = 3'd5;

  // kernel row walk
  typedef enum logic [1:0] {idle, launch, row, done} seq_state_t;

endpackage

/* design/conv_cfg_regs.sv */
`timescale 1ns/10ps

module conv_cfg_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  conv_row_pkg::wb_adr_t wb_adr,
  input  conv_row_pkg::wb_dat_t wb_dat_w,
  output conv_row_pkg::wb_dat_t wb_dat_r,
  output logic                  wb_ack,
  input  logic                  busy,
  input  logic                  desc_pushed,
  output conv_row_pkg::knl_t    k,
  output conv_row_pkg::knl_t    s,
  output conv_row_pkg::knl_t    p,
  output conv_row_pkg::pix_idx_t ix,
  output conv_row_pkg::knl_t    ix_log2,
  output conv_row_pkg::pix_idx_t tile_x_start,
  output conv_row_pkg::pix_idx_t pox,
  output logic                  start
);

  // new request, not yet acked
  logic req;
  conv_row_pkg::pix_idx_t desc_count;

  assign req = wb_cyc && wb_stb && !wb_ack;

  // ack one cycle after the request, write lands on the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack       <= 1'b0;
      start        <= 1'b0;
      k            <= '0;
      s            <= '0;
      p            <= '0;
      ix           <= '0;
      ix_log2      <= '0;
      tile_x_start <= '0;
      pox          <= '0;
    end else begin
      wb_ack <= req;
      // start only from an idle subsystem
      start  <= req && wb_we && (wb_adr == conv_row_pkg::reg_ctrl) && wb_dat_w[0] && !busy;
      if (req && wb_we) begin
        case (wb_adr)
          conv_row_pkg::reg_kernel: begin
            k <= wb_dat_w[3:0];
            s <= wb_dat_w[7:4];
            p <= wb_dat_w[11:8];
          end
          conv_row_pkg::reg_width: begin
            ix      <= wb_dat_w[15:0];
            ix_log2 <= wb_dat_w[19:16];
          end
          conv_row_pkg::reg_tile: tile_x_start <= wb_dat_w[15:0];
          conv_row_pkg::reg_pox:  pox <= wb_dat_w[15:0];
          default: ;
        endcase
      end
    end
  end

  // read data valid together with ack
  always_ff @(posedge clk) begin
    case (wb_adr)
      conv_row_pkg::reg_kernel: wb_dat_r <= {20'd0, p, s, k};
      conv_row_pkg::reg_width:  wb_dat_r <= {12'd0, ix_log2, ix};
      conv_row_pkg::reg_tile:   wb_dat_r <= {16'd0, tile_x_start};
      conv_row_pkg::reg_pox:    wb_dat_r <= {16'd0, pox};
      conv_row_pkg::reg_ctrl:   wb_dat_r <= {31'd0, busy};
      conv_row_pkg::reg_count:  wb_dat_r <= {16'd0, desc_count};
      default:                  wb_dat_r <= '0;
    endcase
  end

  // descriptors issued in the current or last run
  always_ff @(posedge clk) begin
    if (reset || start) begin
      desc_count <= '0;
    end else if (desc_pushed) begin
      desc_count <= desc_count + 16'd1;
    end
  end

  // ack only inside a request already held on the previous edge
  a_ack_follows_req: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> wb_cyc && wb_stb && $past(wb_cyc && wb_stb));

endmodule

/* design/conv_row_sequencer.sv */
`timescale 1ns/10ps

module conv_row_sequencer (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  conv_row_pkg::knl_t k,
  input  logic               loop_adr1_add_end,
  output logic               conv_compute,
  output logic               loop_y_add_end,
  output conv_row_pkg::knl_t ky,
  output logic               busy
);

  conv_row_pkg::seq_state_t state;
  // kernel height held for the whole run
  conv_row_pkg::knl_t k_run;
  logic last_row;

  assign last_row = (ky == k_run - 4'd1);

  //////////////////////////////////////////////////
  // row walk
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= conv_row_pkg::idle;
      ky    <= '0;
      k_run <= '0;
    end else begin
      case (state)
        conv_row_pkg::idle: begin
          if (start) begin
            state <= conv_row_pkg::launch;
            ky    <= '0;
            k_run <= k;
          end
        end
        // one cycle, kicks the generator for this row
        conv_row_pkg::launch: state <= conv_row_pkg::row;
        conv_row_pkg::row: begin
          // wait for the last word of the row
          if (loop_adr1_add_end) begin
            if (last_row) begin
              state <= conv_row_pkg::done;
            end else begin
              ky    <= ky + 4'd1;
              state <= conv_row_pkg::launch;
            end
          end
        end
        default: state <= conv_row_pkg::idle;
      endcase
    end
  end

  assign conv_compute   = (state == conv_row_pkg::launch);
  // flags the whole last row so the generator stops after it
  assign loop_y_add_end = last_row &&
                          (state == conv_row_pkg::launch || state == conv_row_pkg::row);
  assign busy           = (state != conv_row_pkg::idle);

  // a row can only end while the sequencer waits in it
  a_end_in_row: assert property (@(posedge clk) disable iff (reset)
    loop_adr1_add_end |-> (state == conv_row_pkg::row));

endmodule

/* design/conv_pixel_addr_gen.sv */
`timescale 1ns/10ps

module conv_pixel_addr_gen #(
  parameter int pixels_in_row = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  conv_row_pkg::knl_t     k,
  input  conv_row_pkg::knl_t     s,
  input  conv_row_pkg::knl_t     p,
  input  conv_row_pkg::pix_idx_t ix,
  input  conv_row_pkg::knl_t     ix_log2,
  input  conv_row_pkg::pix_idx_t tile_x_start,
  input  conv_row_pkg::pix_idx_t pox,
  input  logic                   conv_compute,
  input  logic                   loop_y_add_end,
  input  logic                   ifx_stall,
  output conv_row_pkg::pad_t     west_pad,
  output conv_row_pkg::pad_t     slab_num,
  output conv_row_pkg::pad_t     east_pad,
  output conv_row_pkg::pix_idx_t row_start_idx,
  output conv_row_pkg::pix_idx_t row_end_idx,
  output conv_row_pkg::pix_idx_t reg_start_idx,
  output conv_row_pkg::pix_idx_t reg_end_idx,
  output conv_row_pkg::pix_idx_t row_slab_start_idx,
  output logic                   valid_adr,
  output logic                   loop_adr1_add_end
);

  localparam conv_row_pkg::pix_idx_t word_pix = conv_row_pkg::pix_idx_t'(pixels_in_row);

  // configuration, tracks the ports while idle and holds during a run
  logic run_active;
  conv_row_pkg::knl_t k_q, s_q, p_q;
  conv_row_pkg::pix_idx_t ix_q, tile_q, pox_q, ix_mask;
  // widened copies for the index arithmetic
  conv_row_pkg::pix_idx_t k16, p16, tile2, ix_start_c;
  // word loop state
  logic signal_adr1_add, adr1_step;
  conv_row_pkg::pix_idx_t adr1, reg_from;
  conv_row_pkg::pad_t row_length, stall_cnt;
  // stage 1
  conv_row_pkg::pix_idx_t ix_start_s1, ix_end_s1, start_idx_s1, end_idx_s1, slab_s1;
  conv_row_pkg::pad_t west_s1, slabn_s1;
  // stage 2
  conv_row_pkg::pix_idx_t trimmed_c, row_end_c, row_end_fix_c, reg_to_c;
  conv_row_pkg::pad_t right_pad_c;
  conv_row_pkg::pix_idx_t row_start_fix_s2, row_end_fix_s2, reg_to_s2;
  conv_row_pkg::pix_idx_t start_idx_s2, end_idx_s2, slab_s2;
  conv_row_pkg::pad_t right_pad_s2, west_s2, slabn_s2;

  // set by the first row, cleared when the last row ends
  always_ff @(posedge clk) begin
    if (reset) begin
      run_active <= 1'b0;
    end else if (conv_compute) begin
      run_active <= 1'b1;
    end else if (loop_adr1_add_end && loop_y_add_end) begin
      run_active <= 1'b0;
    end
  end

  // last load happens on the conv_compute edge of the first row
  always_ff @(posedge clk) begin
    if (!run_active) begin
      k_q     <= k;
      s_q     <= s;
      p_q     <= p;
      ix_q    <= ix;
      tile_q  <= tile_x_start;
      pox_q   <= pox;
      ix_mask <= 16'hffff >> (5'd16 - {1'b0, ix_log2});
    end
  end

  assign k16   = conv_row_pkg::pix_idx_t'(k_q);
  assign p16   = conv_row_pkg::pix_idx_t'(p_q);
  assign tile2 = tile_q << 1;
  // first input column of the tile, stride 1 or 2
  assign ix_start_c = (s_q == 4'd1) ? tile_q : (s_q == 4'd2) ? tile2 - 16'd1 : '0;

  //////////////////////////////////////////////////
  // stage 1, tile bounds and per word indices
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    ix_start_s1  <= ix_start_c;
    ix_end_s1    <= (s_q == 4'd1) ? tile_q + k16 + pox_q - 16'd2 :
                    (s_q == 4'd2) ? tile2 + k16 + (pox_q << 1) - 16'd4 : '0;
    start_idx_s1 <= adr1 + ix_start_c - 16'd1;
    end_idx_s1   <= adr1 + ix_start_c + word_pix - 16'd2;
    // interior tile with padding reuses a slab of the previous word
    slab_s1      <= (adr1 == '0 && tile_q != 16'd1 && p_q != '0) ?
                    adr1 + ix_start_c - 16'd33 : 16'hffff;
    // left edge of the image
    west_s1      <= (adr1 == '0 && tile_q == 16'd1) ? p_q : '0;
    slabn_s1     <= (adr1 == '0 && tile_q != 16'd1) ? p_q : '0;
  end

  //////////////////////////////////////////////////
  // stage 2, right pad and aligned row end
  //////////////////////////////////////////////////
  assign right_pad_c = (ix_end_s1 > p16 + ix_q) ?
                       conv_row_pkg::pad_t'(ix_end_s1 - p16 - ix_q) : '0;
  assign trimmed_c   = ix_end_s1 - conv_row_pkg::pix_idx_t'(right_pad_c) - p16;
  assign row_end_c   = trimmed_c - 16'd1;
  // round up to the end of a 32 pixel word, clipped to the image
  assign row_end_fix_c = (trimmed_c[4:0] == 5'd0) ? (trimmed_c - 16'd1) & ix_mask :
                         ((trimmed_c & 16'hffe0) + 16'h001f) & ix_mask;
  // last word may hold fewer pixels than a full word
  assign reg_to_c = (start_idx_s1 + word_pix - 16'd1 > row_end_c) ?
                    reg_from + row_end_c - start_idx_s1 : reg_from + word_pix - 16'd1;

  always_ff @(posedge clk) begin
    row_start_fix_s2 <= ix_start_s1 - 16'd1;
    row_end_fix_s2   <= row_end_fix_c;
    right_pad_s2     <= right_pad_c;
    reg_to_s2        <= reg_to_c;
    start_idx_s2     <= start_idx_s1;
    end_idx_s2       <= end_idx_s1;
    slab_s2          <= slab_s1;
    west_s2          <= west_s1;
    slabn_s2         <= slabn_s1;
  end

  //////////////////////////////////////////////////
  // word loop
  //////////////////////////////////////////////////
  assign adr1_step         = signal_adr1_add && (stall_cnt == '0) && !ifx_stall;
  assign loop_adr1_add_end = adr1_step &&
                             (adr1 + word_pix > row_end_fix_s2 - row_start_fix_s2);

  always_ff @(posedge clk) begin
    if (reset) begin
      signal_adr1_add <= 1'b0;
    end else if (conv_compute) begin
      signal_adr1_add <= 1'b1;
    end else if (loop_adr1_add_end) begin
      signal_adr1_add <= 1'b0;
    end
  end

  // idle keeps the counters at their row start so the pipeline is settled
  always_ff @(posedge clk) begin
    if (reset) begin
      adr1     <= '0;
      reg_from <= '0;
    end else if (!run_active || loop_adr1_add_end) begin
      adr1     <= '0;
      reg_from <= p16 + 16'd1;
    end else if (adr1_step) begin
      adr1     <= adr1 + word_pix;
      reg_from <= reg_to_s2 + 16'd1;
    end
  end

  // words issued in the current row
  always_ff @(posedge clk) begin
    if (reset) begin
      row_length <= '0;
    end else if (conv_compute || loop_adr1_add_end) begin
      row_length <= 4'd1;
    end else if (adr1_step) begin
      row_length <= row_length + 4'd1;
    end
  end

  // gap after each word, longer between rows for short rows
  always_ff @(posedge clk) begin
    if (reset) begin
      stall_cnt <= '0;
    end else if (adr1_step) begin
      if (loop_adr1_add_end && loop_y_add_end) begin
        stall_cnt <= '0;
      end else if (loop_adr1_add_end) begin
        stall_cnt <= ({1'b0, k_q} >= {1'b0, row_length} + 5'd4) ?
                     k_q - row_length - 4'd2 : 4'd2;
      end else begin
        stall_cnt <= 4'd2;
      end
    end else if (stall_cnt != '0) begin
      stall_cnt <= stall_cnt - 4'd1;
    end
  end

  assign valid_adr          = adr1_step;
  assign row_start_idx      = start_idx_s2;
  assign row_end_idx        = end_idx_s2;
  assign row_slab_start_idx = slab_s2;
  assign west_pad           = west_s2;
  assign slab_num           = slabn_s2;
  assign reg_start_idx      = reg_from;
  assign east_pad           = loop_adr1_add_end ? right_pad_s2 : '0;
  assign reg_end_idx        = reg_to_s2 + conv_row_pkg::pix_idx_t'(east_pad);

  // two quiet cycles after every push while the pipeline refills
  a_push_spacing: assert property (@(posedge clk) disable iff (reset)
    valid_adr |=> !valid_adr [*2]);

endmodule

/* design/conv_desc_queue.sv */
`timescale 1ns/10ps

module conv_desc_queue (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  conv_row_pkg::knl_t     ky_in,
  input  conv_row_pkg::pix_idx_t row_start_idx,
  input  conv_row_pkg::pix_idx_t row_end_idx,
  input  conv_row_pkg::pix_idx_t reg_start_idx,
  input  conv_row_pkg::pix_idx_t reg_end_idx,
  input  conv_row_pkg::pix_idx_t row_slab_start_idx,
  input  conv_row_pkg::pad_t     west_pad,
  input  conv_row_pkg::pad_t     east_pad,
  input  conv_row_pkg::pad_t     slab_num,
  output logic                   ifx_stall,
  output logic                   desc_valid,
  input  logic                   desc_ready,
  output conv_row_pkg::knl_t     desc_ky,
  output conv_row_pkg::pix_idx_t desc_row_start_idx,
  output conv_row_pkg::pix_idx_t desc_row_end_idx,
  output conv_row_pkg::pix_idx_t desc_reg_start_idx,
  output conv_row_pkg::pix_idx_t desc_reg_end_idx,
  output conv_row_pkg::pix_idx_t desc_row_slab_start_idx,
  output conv_row_pkg::pad_t     desc_west_pad,
  output conv_row_pkg::pad_t     desc_east_pad,
  output conv_row_pkg::pad_t     desc_slab_num
);

  // ky, five indices, three pad counts
  localparam int desc_w = 96;

  logic [desc_w-1:0] mem [4];
  logic [1:0] wr_ptr, rd_ptr;
  logic [2:0] count;
  logic pop;

  assign pop = desc_valid && desc_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {ky_in, row_start_idx, row_end_idx, reg_start_idx, reg_end_idx,
                      row_slab_start_idx, west_pad, east_pad, slab_num};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 2'd1;
      if (pop) rd_ptr <= rd_ptr + 2'd1;
      // simultaneous push and pop leaves the count alone
      if (push && !pop) count <= count + 3'd1;
      else if (pop && !push) count <= count - 3'd1;
    end
  end

  // head entry drives the output
  assign {desc_ky, desc_row_start_idx, desc_row_end_idx, desc_reg_start_idx, desc_reg_end_idx,
          desc_row_slab_start_idx, desc_west_pad, desc_east_pad, desc_slab_num} = mem[rd_ptr];
  assign desc_valid = (count != '0);
  // one slot kept free for the word already in flight
  assign ifx_stall  = (count >= 3'd3);

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> count < 3'd4);

endmodule

/* design/conv_fetch_top.sv */
`timescale 1ns/10ps

module conv_fetch_top #(
  parameter int pixels_in_row = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  conv_row_pkg::wb_adr_t  wb_adr,
  input  conv_row_pkg::wb_dat_t  wb_dat_w,
  output conv_row_pkg::wb_dat_t  wb_dat_r,
  output logic                   wb_ack,
  output logic                   desc_valid,
  input  logic                   desc_ready,
  output conv_row_pkg::knl_t     desc_ky,
  output conv_row_pkg::pix_idx_t desc_row_start_idx,
  output conv_row_pkg::pix_idx_t desc_row_end_idx,
  output conv_row_pkg::pix_idx_t desc_reg_start_idx,
  output conv_row_pkg::pix_idx_t desc_reg_end_idx,
  output conv_row_pkg::pix_idx_t desc_row_slab_start_idx,
  output conv_row_pkg::pad_t     desc_west_pad,
  output conv_row_pkg::pad_t     desc_east_pad,
  output conv_row_pkg::pad_t     desc_slab_num
);

  // configuration
  conv_row_pkg::knl_t k, s, p, ix_log2, ky;
  conv_row_pkg::pix_idx_t ix, tile_x_start, pox;
  logic start, busy;
  // row control
  logic conv_compute, loop_y_add_end, loop_adr1_add_end;
  // descriptor into the queue
  logic valid_adr, ifx_stall;
  conv_row_pkg::pad_t west_pad, east_pad, slab_num;
  conv_row_pkg::pix_idx_t row_start_idx, row_end_idx, reg_start_idx, reg_end_idx;
  conv_row_pkg::pix_idx_t row_slab_start_idx;

  conv_cfg_regs u_cfg_regs (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .busy, .desc_pushed(valid_adr), .k, .s, .p, .ix, .ix_log2, .tile_x_start, .pox, .start
  );

  conv_row_sequencer u_row_sequencer (
    .clk, .reset, .start, .k, .loop_adr1_add_end, .conv_compute, .loop_y_add_end, .ky, .busy
  );

  conv_pixel_addr_gen #(.pixels_in_row(pixels_in_row)) u_pixel_addr_gen (
    .clk, .reset, .k, .s, .p, .ix, .ix_log2, .tile_x_start, .pox,
    .conv_compute, .loop_y_add_end, .ifx_stall,
    .west_pad, .slab_num, .east_pad, .row_start_idx, .row_end_idx,
    .reg_start_idx, .reg_end_idx, .row_slab_start_idx, .valid_adr, .loop_adr1_add_end
  );

  // ky rides along from the sequencer at push time
  conv_desc_queue u_desc_queue (
    .clk, .reset, .push(valid_adr), .ky_in(ky),
    .row_start_idx, .row_end_idx, .reg_start_idx, .reg_end_idx, .row_slab_start_idx,
    .west_pad, .east_pad, .slab_num, .ifx_stall, .desc_valid, .desc_ready,
    .desc_ky, .desc_row_start_idx, .desc_row_end_idx, .desc_reg_start_idx,
    .desc_reg_end_idx, .desc_row_slab_start_idx, .desc_west_pad, .desc_east_pad,
    .desc_slab_num
  );

endmodule

/* verification/conv_fetch_tb.sv */
`timescale 1ns/10ps

module conv_fetch_tb;

  localparam int pixels_in_row = 32;
  localparam int max_tests = 16;
  localparam int max_desc = 256;
  localparam int cycles_per_test = 400;

  // DUT ports
  logic clk, reset, wb_cyc, wb_stb, wb_we, wb_ack, desc_valid, desc_ready;
  conv_row_pkg::wb_adr_t wb_adr;
  conv_row_pkg::wb_dat_t wb_dat_w, wb_dat_r;
  conv_row_pkg::knl_t desc_ky;
  conv_row_pkg::pix_idx_t desc_row_start_idx, desc_row_end_idx, desc_reg_start_idx;
  conv_row_pkg::pix_idx_t desc_reg_end_idx, desc_row_slab_start_idx;
  conv_row_pkg::pad_t desc_west_pad, desc_east_pad, desc_slab_num;

  // stimulus file contents, one row per configuration or descriptor
  int cfg [max_tests][7];
  int exp_desc [max_desc][9];
  int desc_base [max_tests];
  int desc_n [max_tests];
  int num_tests, num_desc;
  bit file_ok;
  // expected window of the run in progress
  int cur_base, cur_n, rx_count;
  int checks, errors;
  int cycle_count;
  int cycle_limit = cycles_per_test;
  int seed = 23707;
  int rnd;

  conv_fetch_top #(.pixels_in_row(pixels_in_row)) u_conv_fetch_top (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .desc_valid, .desc_ready, .desc_ky, .desc_row_start_idx, .desc_row_end_idx,
    .desc_reg_start_idx, .desc_reg_end_idx, .desc_row_slab_start_idx,
    .desc_west_pad, .desc_east_pad, .desc_slab_num
  );

  // 8 ns period
  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task check_value(input string name, input logic [31:0] exp_v, input logic [31:0] got_v);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, got_v);
    end
  endtask

  // one classic cycle, called and left 1 ns after a rising edge
  task bus_access(input logic we, input conv_row_pkg::wb_adr_t adr,
                  input conv_row_pkg::wb_dat_t wdata, output conv_row_pkg::wb_dat_t rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waited   = 0;
    @(negedge clk);
    while (!wb_ack) begin
      waited++;
      @(negedge clk);
    end
    rdata = wb_dat_r;
    // ack belongs one cycle after the request
    check_value("wb_ack latency", 32'd1, waited);
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task compare_desc(input int i);
    check_value("desc_ky", exp_desc[i][0], 32'(desc_ky));
    check_value("desc_row_start_idx", exp_desc[i][1], 32'(desc_row_start_idx));
    check_value("desc_row_end_idx", exp_desc[i][2], 32'(desc_row_end_idx));
    check_value("desc_reg_start_idx", exp_desc[i][3], 32'(desc_reg_start_idx));
    check_value("desc_reg_end_idx", exp_desc[i][4], 32'(desc_reg_end_idx));
    check_value("desc_row_slab_start_idx", exp_desc[i][5], 32'(desc_row_slab_start_idx));
    check_value("desc_west_pad", exp_desc[i][6], 32'(desc_west_pad));
    check_value("desc_east_pad", exp_desc[i][7], 32'(desc_east_pad));
    check_value("desc_slab_num", exp_desc[i][8], 32'(desc_slab_num));
  endtask

  // C lines open a test, D lines add its expected descriptors
  task load_stimulus();
    int fd, ch, n;
    byte tag;
    int v [9];
    fd = $fopen("verification/conv_fetch_stimulus.txt", "r");
    if (fd != 0) begin
      file_ok = 1'b1;
      while ($fscanf(fd, " %c", tag) == 1) begin
        if (tag == "#") begin
          ch = $fgetc(fd);
          while (ch != "\n" && ch != -1) ch = $fgetc(fd);
        end else if (tag == "C" && num_tests < max_tests) begin
          n = $fscanf(fd, " %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
          if (n != 7) file_ok = 1'b0;
          for (int j = 0; j < 7; j++) cfg[num_tests][j] = v[j];
          desc_base[num_tests] = num_desc;
          desc_n[num_tests] = 0;
          num_tests++;
        end else if (tag == "D" && num_tests > 0 && num_desc < max_desc) begin
          n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
          if (n != 9) file_ok = 1'b0;
          for (int j = 0; j < 9; j++) exp_desc[num_desc][j] = v[j];
          desc_n[num_tests-1]++;
          num_desc++;
        end else begin
          file_ok = 1'b0;
        end
      end
      $fclose(fd);
    end
  endtask

  task run_test(input int t);
    conv_row_pkg::wb_dat_t rd, kernel_word, width_word, other_kernel;
    bit saw_busy;
    int other;
    kernel_word = conv_row_pkg::wb_dat_t'((cfg[t][2] << 8) | (cfg[t][1] << 4) | cfg[t][0]);
    width_word  = conv_row_pkg::wb_dat_t'((cfg[t][4] << 16) | cfg[t][3]);
    other = (t + 1) % num_tests;
    other_kernel = conv_row_pkg::wb_dat_t'((cfg[other][2] << 8) | (cfg[other][1] << 4) |
                                           cfg[other][0]);
    bus_access(1'b1, conv_row_pkg::reg_kernel, kernel_word, rd);
    bus_access(1'b1, conv_row_pkg::reg_width, width_word, rd);
    bus_access(1'b1, conv_row_pkg::reg_tile, cfg[t][5], rd);
    bus_access(1'b1, conv_row_pkg::reg_pox, cfg[t][6], rd);
    // readback of every field
    bus_access(1'b0, conv_row_pkg::reg_kernel, '0, rd);
    check_value("reg_kernel", kernel_word, rd);
    bus_access(1'b0, conv_row_pkg::reg_width, '0, rd);
    check_value("reg_width", width_word, rd);
    bus_access(1'b0, conv_row_pkg::reg_tile, '0, rd);
    check_value("reg_tile", cfg[t][5], rd);
    bus_access(1'b0, conv_row_pkg::reg_pox, '0, rd);
    check_value("reg_pox", cfg[t][6], rd);
    cur_base = desc_base[t];
    cur_n    = desc_n[t];
    rx_count = 0;
    bus_access(1'b1, conv_row_pkg::reg_ctrl, 32'd1, rd);
    // rewrite the registers mid run while the run keeps its latched copy
    bus_access(1'b1, conv_row_pkg::reg_kernel, other_kernel, rd);
    bus_access(1'b1, conv_row_pkg::reg_tile, cfg[other][5], rd);
    bus_access(1'b1, conv_row_pkg::reg_pox, cfg[other][6], rd);
    // poll busy until the row walk ends
    saw_busy = 1'b0;
    do begin
      bus_access(1'b0, conv_row_pkg::reg_ctrl, '0, rd);
      if (rd[0]) saw_busy = 1'b1;
    end while (rd[0]);
    checks++;
    if (!saw_busy) begin
      errors++;
      $display("busy never went high after start in test %0d", t);
    end
    // every descriptor is pushed by the time busy falls
    bus_access(1'b0, conv_row_pkg::reg_count, '0, rd);
    check_value("reg_count", cur_n, rd);
    // sink may still be draining the queue
    while (rx_count < cur_n) begin
      @(posedge clk);
      #1;
    end
    @(negedge clk);
    checks++;
    if (desc_valid) begin
      errors++;
      $display("queue still holds a descriptor after test %0d ended", t);
    end
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // sink, monitor and timeout
  //////////////////////////////////////////////////

  // ready about one cycle in four so the queue fills and stalls the generator
  always @(posedge clk) begin
    #1;
    rnd = $random(seed);
    desc_ready = (rnd[1:0] == 2'b00);
  end

  // a transfer happens on the next edge, both sides are stable here
  always @(negedge clk) begin
    if (!reset && desc_valid && desc_ready) begin
      if (rx_count >= cur_n) begin
        errors++;
        $display("unexpected descriptor at %0t ns, only %0d expected", $time, cur_n);
      end else begin
        compare_desc(cur_base + rx_count);
      end
      rx_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      errors++;
      $display("timeout after %0d cycles, the run did not complete", cycle_count);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    desc_ready = 1'b0;
    load_stimulus();
    cycle_limit = cycles_per_test * ((num_tests > 0) ? num_tests : 1);
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    if (!file_ok || num_tests == 0) begin
      errors++;
      $display("stimulus file missing or malformed");
    end else begin
      for (int t = 0; t < num_tests; t++) run_test(t);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verification/conv_fetch_stimulus.txt */
# C k s p ix ix_log2 tile_x_start pox (hex), one run
# D ky row_start row_end reg_start reg_end slab_start west east slab (hex), expected order
# stride 1, first tile, two words per row
C 3 1 1 40 6 1 40
D 0 0000 001f 0002 0021 ffff 1 0 0
D 0 0020 003f 0022 0042 ffff 0 1 0
D 1 0000 001f 0002 0021 ffff 1 0 0
D 1 0020 003f 0022 0042 ffff 0 1 0
D 2 0000 001f 0002 0021 ffff 1 0 0
D 2 0020 003f 0022 0042 ffff 0 1 0
# stride 2, interior tile at the right edge
C 3 2 1 7f 7 21 20
D 0 0040 005f 0002 0021 0020 0 0 1
D 0 0060 007f 0022 0041 ffff 0 1 0
D 1 0040 005f 0002 0021 0020 0 0 1
D 1 0060 007f 0022 0041 ffff 0 1 0
D 2 0040 005f 0002 0021 0020 0 0 1
D 2 0060 007f 0022 0041 ffff 0 1 0
# stride 1, k 5, one short word per row
C 5 1 2 20 5 1 8
D 0 0000 001f 0003 000c ffff 2 0 0
D 1 0000 001f 0003 000c ffff 2 0 0
D 2 0000 001f 0003 000c ffff 2 0 0
D 3 0000 001f 0003 000c ffff 2 0 0
D 4 0000 001f 0003 000c ffff 2 0 0
# stride 2, k 7, interior tile with a slab
C 7 2 3 40 6 15 4
D 0 0028 0047 0004 000d 0008 0 0 3
D 1 0028 0047 0004 000d 0008 0 0 3
D 2 0028 0047 0004 000d 0008 0 0 3
D 3 0028 0047 0004 000d 0008 0 0 3
D 4 0028 0047 0004 000d 0008 0 0 3
D 5 0028 0047 0004 000d 0008 0 0 3
D 6 0028 0047 0004 000d 0008 0 0 3

/* flist.f */
design/conv_row_pkg.sv
design/conv_cfg_regs.sv
design/conv_row_sequencer.sv
design/conv_pixel_addr_gen.sv
design/conv_desc_queue.sv
design/conv_fetch_top.sv
verification/conv_fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the descriptor fetch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f \
  --top-module conv_fetch_tb \
  -o conv_fetch_sim

./obj_dir/conv_fetch_sim > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
  exit 1
fi
exit 0
